/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Geometry for 32-byte lines in eight sets
`define OFFSET_BITS 5
`define INDEX_BITS  3
`define TAG_BITS    (32 - `OFFSET_BITS - `INDEX_BITS)

// One line in bits
`define LINE_BITS   (8 * (1 << `OFFSET_BITS))

`define NUM_SETS    (1 << `INDEX_BITS)

// Words held in one line
`define LINE_WORDS  (`LINE_BITS / 32)

`endif

/* cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

    // Address split as the cache core sees it
    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`INDEX_BITS-1:0]  index;
        logic [`OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    // Same 32-bit word seen flat or split
    typedef union packed {
        logic [31:0]  flat;
        addr_fields_t fields;
    } cache_addr_u;

    // Processor side request
    typedef struct packed {
        logic        read;
        logic        write;
        cache_addr_u address;
        logic [3:0]  byte_en;
        logic [31:0] wdata;
    } cpu_req_t;

    // Line transfer toward memory
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [31:0]           address;   // Line aligned
        logic [`LINE_BITS-1:0] wdata;
    } line_req_t;

    typedef struct packed {
        logic                  resp;      // One cycle pulse
        logic [`LINE_BITS-1:0] rdata;
    } line_rsp_t;

endpackage

/* word_lane_unit.sv */
`include "cache_macros.svh"

module word_lane_unit (
    input  logic [`LINE_BITS-1:0]   line_in,
    input  logic [31:0]             word_in,
    input  logic [3:0]              byte_en,
    input  logic [`OFFSET_BITS-1:0] offset,
    output logic [`LINE_BITS-1:0]   line_out,
    output logic [31:0]             word_out
);

    logic [`OFFSET_BITS-3:0] word_sel;
    logic [31:0]             word_base;

    // Accesses are word aligned so the low offset bits are ignored
    assign word_sel  = offset[`OFFSET_BITS-1:2];
    assign word_base = 32'(word_sel) * 32;

    // Extract path
    assign word_out = line_in[word_base +: 32];

    // Insert path leaves the line as is when no byte is enabled
    always_comb begin
        line_out = line_in;
        for (int b = 0; b < 4; b++) begin
            if (byte_en[b]) begin
                line_out[word_base + 32'(b) * 8 +: 8] = word_in[b*8 +: 8];
            end
        end
    end

endmodule

/* cache_core.sv */
`include "cache_macros.svh"

module cache_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::cpu_req_t   req,
    input  logic [`LINE_BITS-1:0] fill_line,
    input  cache_pkg::line_rsp_t  mem_rsp,
    output logic [`LINE_BITS-1:0] line_rdata,
    output logic                  resp,
    output cache_pkg::line_req_t  mem_req
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } state_t;

    state_t state;
    state_t state_next;

    logic [`TAG_BITS-1:0]   tag_arr  [`NUM_SETS];
    logic [`LINE_BITS-1:0]  data_arr [`NUM_SETS];
    logic [`NUM_SETS-1:0]   valid;
    logic [`NUM_SETS-1:0]   dirty;

    logic [`INDEX_BITS-1:0] idx;
    logic [`TAG_BITS-1:0]   tag;
    logic                   hit;
    logic                   wr_hit;
    logic                   refill_done;
    logic                   line_we;
    logic [`LINE_BITS-1:0]  line_wdata;
    cache_pkg::cache_addr_u victim_addr;
    cache_pkg::cache_addr_u fill_addr;

    // Request fields stay stable until resp
    assign idx = req.address.fields.index;
    assign tag = req.address.fields.tag;
    assign hit = valid[idx] && (tag_arr[idx] == tag);

    assign wr_hit      = (state == LOOKUP) && hit && req.write;
    assign refill_done = (state == REFILL) && mem_rsp.resp;

    // Store merges into hit data or into the refilled line
    assign line_we    = wr_hit || refill_done;
    assign line_wdata = req.write ? fill_line : mem_rsp.rdata;

    // Refill data goes straight to the lane unit
    assign line_rdata = (state == REFILL) ? mem_rsp.rdata : data_arr[idx];

    assign resp = (state == RESPOND);

    always_comb begin
        victim_addr.fields.tag    = tag_arr[idx];
        victim_addr.fields.index  = idx;
        victim_addr.fields.offset = '0;

        fill_addr.fields.tag      = tag;
        fill_addr.fields.index    = idx;
        fill_addr.fields.offset   = '0;
    end

    always_comb begin
        mem_req.read    = (state == REFILL);
        mem_req.write   = (state == WRITEBACK);
        mem_req.address = (state == WRITEBACK) ? victim_addr.flat : fill_addr.flat;
        mem_req.wdata   = data_arr[idx];   // Victim line
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req.read || req.write) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_next = RESPOND;
                end else if (valid[idx] && dirty[idx]) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = REFILL;
                end
            end
            WRITEBACK: begin
                if (mem_rsp.resp) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (mem_rsp.resp) begin
                    state_next = RESPOND;
                end
            end
            RESPOND: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            valid <= '0;
            dirty <= '0;
        end else begin
            state <= state_next;
            if (wr_hit) begin
                dirty[idx] <= 1'b1;
            end else if (refill_done) begin
                valid[idx] <= 1'b1;
                dirty[idx] <= req.write;   // Store miss leaves the line dirty
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            data_arr[idx] <= line_wdata;
        end
        if (refill_done) begin
            tag_arr[idx] <= tag;
        end
    end

endmodule

/* mem_arbiter.sv */
module mem_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::line_req_t icache_req,
    input  cache_pkg::line_req_t dcache_req,
    input  cache_pkg::line_rsp_t pmem_rsp,
    output cache_pkg::line_rsp_t icache_rsp,
    output cache_pkg::line_rsp_t dcache_rsp,
    output cache_pkg::line_req_t pmem_req
);

    logic i_pend;
    logic d_pend;
    logic pick_d;
    logic busy;
    logic grant_d;   // Current grant or the last one while idle

    assign i_pend = icache_req.read || icache_req.write;
    assign d_pend = dcache_req.read || dcache_req.write;

    // Round robin on a tie with dcache first after reset
    always_comb begin
        if (i_pend && d_pend) begin
            pick_d = ~grant_d;
        end else begin
            pick_d = d_pend;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            grant_d  <= 1'b0;
            pmem_req <= '0;
        end else if (busy) begin
            // Hold the request until memory answers
            if (pmem_rsp.resp) begin
                busy           <= 1'b0;
                pmem_req.read  <= 1'b0;
                pmem_req.write <= 1'b0;
            end
        end else if (i_pend || d_pend) begin
            busy     <= 1'b1;
            grant_d  <= pick_d;
            pmem_req <= pick_d ? dcache_req : icache_req;
        end
    end

    // Only the granted core sees resp
    always_comb begin
        icache_rsp.rdata = pmem_rsp.rdata;
        icache_rsp.resp  = pmem_rsp.resp && busy && !grant_d;
        dcache_rsp.rdata = pmem_rsp.rdata;
        dcache_rsp.resp  = pmem_rsp.resp && busy && grant_d;
    end

endmodule

/* cache_hierarchy.sv */
`include "cache_macros.svh"

module cache_hierarchy (
    input  logic                 clk,
    input  logic                 rst_n,

    input  cache_pkg::cpu_req_t  imem_req,
    output logic [31:0]          imem_rdata,
    output logic                 imem_resp,

    input  cache_pkg::cpu_req_t  dmem_req,
    output logic [31:0]          dmem_rdata,
    output logic                 dmem_resp,

    output cache_pkg::line_req_t pmem_req,
    input  cache_pkg::line_rsp_t pmem_rsp
);

    cache_pkg::cpu_req_t   icache_req;
    cache_pkg::line_req_t  icache_mem_req;
    cache_pkg::line_req_t  dcache_mem_req;
    cache_pkg::line_rsp_t  icache_mem_rsp;
    cache_pkg::line_rsp_t  dcache_mem_rsp;

    logic [`LINE_BITS-1:0] icache_line;
    logic [`LINE_BITS-1:0] icache_fill;
    logic [`LINE_BITS-1:0] dcache_line;
    logic [`LINE_BITS-1:0] dcache_fill;

    // Instruction side never writes
    assign icache_req = '{
        read:    imem_req.read,
        write:   1'b0,
        address: imem_req.address,
        byte_en: 4'b0,
        wdata:   32'b0
    };

    cache_core icache_core (
        .clk,
        .rst_n,
        .req        (icache_req),
        .fill_line  (icache_fill),
        .mem_rsp    (icache_mem_rsp),
        .line_rdata (icache_line),
        .resp       (imem_resp),
        .mem_req    (icache_mem_req)
    );

    // Extract only
    word_lane_unit ilane (
        .line_in  (icache_line),
        .word_in  (32'b0),
        .byte_en  (4'b0),
        .offset   (imem_req.address.fields.offset),
        .line_out (icache_fill),
        .word_out (imem_rdata)
    );

    cache_core dcache_core (
        .clk,
        .rst_n,
        .req        (dmem_req),
        .fill_line  (dcache_fill),
        .mem_rsp    (dcache_mem_rsp),
        .line_rdata (dcache_line),
        .resp       (dmem_resp),
        .mem_req    (dcache_mem_req)
    );

    word_lane_unit dlane (
        .line_in  (dcache_line),
        .word_in  (dmem_req.wdata),
        .byte_en  (dmem_req.byte_en),
        .offset   (dmem_req.address.fields.offset),
        .line_out (dcache_fill),
        .word_out (dmem_rdata)
    );

    mem_arbiter arbiter (
        .clk,
        .rst_n,
        .icache_req (icache_mem_req),
        .dcache_req (dcache_mem_req),
        .pmem_rsp,
        .icache_rsp (icache_mem_rsp),
        .dcache_rsp (dcache_mem_rsp),
        .pmem_req
    );

endmodule

/* cache_hierarchy_sva.sv */
module cache_hierarchy_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 imem_resp,
    input logic                 dmem_resp,
    input cache_pkg::line_req_t pmem_req,
    input cache_pkg::line_rsp_t pmem_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(pmem_req.read && pmem_req.write))
        else $error("pmem read and write high together");

    // Arbiter keeps the granted transfer until memory answers
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (pmem_req.read || pmem_req.write) && !pmem_rsp.resp |=> $stable(pmem_req))
        else $error("pmem request changed before resp");

    imem_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        imem_resp |=> !imem_resp)
        else $error("imem_resp longer than one cycle");

    dmem_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_resp |=> !dmem_resp)
        else $error("dmem_resp longer than one cycle");

endmodule

bind cache_hierarchy cache_hierarchy_sva sva_i (.clk, .rst_n, .imem_resp, .dmem_resp,
                                                .pmem_req, .pmem_rsp);

/* pmem_model.sv */
`include "cache_macros.svh"

module pmem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::line_req_t req,
    output cache_pkg::line_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DELAY = 4;   // Cycles from request to resp

    logic [`LINE_BITS-1:0] lines [logic [31:0]];   // Lines written back so far
    logic [31:0]           line_addr;
    int                    wait_cnt;

    // Untouched memory holds each word's own byte address
    function automatic logic [`LINE_BITS-1:0] initial_line(input logic [31:0] base);
        logic [`LINE_BITS-1:0] l;
        for (int k = 0; k < `LINE_WORDS; k++) begin
            l[k*32 +: 32] = base + 32'(k) * 4;
        end
        return l;
    endfunction

    assign line_addr = {req.address[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= 0;
            rsp      <= '0;
        end else begin
            rsp.resp <= 1'b0;
            if ((req.read || req.write) && !rsp.resp) begin
                if (wait_cnt == DELAY - 1) begin
                    wait_cnt <= 0;
                    rsp.resp <= 1'b1;
                    if (req.write) begin
                        lines[line_addr] = req.wdata;
                    end else if (lines.exists(line_addr)) begin
                        rsp.rdata <= lines[line_addr];
                    end else begin
                        rsp.rdata <= initial_line(line_addr);
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

/* tb_cache_hierarchy.sv */
module tb_cache_hierarchy;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS    = 5;
    localparam int MAX_ACCESSES = 60;
    localparam int ACCESS_NS    = 60;
    localparam int WATCHDOG_NS  = NUM_TESTS * MAX_ACCESSES * ACCESS_NS + 2000;
    localparam int RESP_LIMIT   = 100;   // Cycles far above a dirty miss

    logic                 clk;
    logic                 rst_n;
    cache_pkg::cpu_req_t  imem_req;
    cache_pkg::cpu_req_t  dmem_req;
    logic [31:0]          imem_rdata;
    logic [31:0]          dmem_rdata;
    logic                 imem_resp;
    logic                 dmem_resp;
    cache_pkg::line_req_t pmem_req;
    cache_pkg::line_rsp_t pmem_rsp;

    int          checks = 0;
    int          errors = 0;
    logic [31:0] ref_mem [logic [31:0]];   // Words changed by stores
    logic [31:0] stored_addrs [$];

    cache_hierarchy cache_hierarchy_i (.clk, .rst_n, .imem_req, .imem_rdata, .imem_resp,
                                       .dmem_req, .dmem_rdata, .dmem_resp, .pmem_req, .pmem_rsp);

    pmem_model pmem (.clk, .rst_n, .req(pmem_req), .rsp(pmem_rsp));

    always #5 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0d ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a;   // Initial memory pattern
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) w[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return w;
    endfunction

    task automatic dmem_access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int lat);
        @(negedge clk);
        dmem_req = '{read: !wr, write: wr, address: addr, byte_en: be, wdata: wdata};
        lat = 0;
        while (!dmem_resp && lat < RESP_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!dmem_resp) begin
            errors++;
            $display("dmem request to %h got no response within %0d cycles", addr, lat);
        end
        rdata = dmem_rdata;
        dmem_req.read  = 1'b0;
        dmem_req.write = 1'b0;
    endtask

    task automatic imem_access(input logic [31:0] addr, output logic [31:0] rdata,
                               output int lat);
        @(negedge clk);
        imem_req = '{read: 1'b1, write: 1'b0, address: addr, byte_en: 4'h0, wdata: 32'h0};
        lat = 0;
        while (!imem_resp && lat < RESP_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!imem_resp) begin
            errors++;
            $display("imem fetch from %h got no response within %0d cycles", addr, lat);
        end
        rdata = imem_rdata;
        imem_req.read = 1'b0;
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        logic [31:0] unused;
        int lat;
        dmem_access(1'b1, addr, be, data, unused, lat);
        ref_mem[{addr[31:2], 2'b00}] = merge_bytes(expected_word(addr), data, be);
        stored_addrs.push_back(addr);
    endtask

    task automatic load_and_check(input string what, input logic [31:0] addr);
        logic [31:0] word;
        int lat;
        dmem_access(1'b0, addr, 4'h0, 32'h0, word, lat);
        check(what, word, expected_word(addr));
    endtask

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        repeat (4) begin
            @(negedge clk);
            check("imem_resp after reset", 32'(imem_resp), 32'd0);
            check("dmem_resp after reset", 32'(dmem_resp), 32'd0);
            check("pmem strobes after reset", 32'({pmem_req.read, pmem_req.write}), 32'd0);
        end
        $display("idle_after_reset done, %0d mismatches", errors - e0);
    endtask

    task automatic ifetch_miss_then_hit();
        logic [31:0] addr;
        logic [31:0] word;
        int lat;
        int e0;
        e0 = errors;
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 8; i++) begin
                addr = 32'h0000_4000 + 32'(i) * 32 + 32'(7 - i) * 4;   // One line per set
                imem_access(addr, word, lat);
                check("ifetch word", word, expected_word(addr));
                if (pass == 1) check("ifetch hit latency", 32'(lat), 32'd2);
            end
        end
        $display("ifetch_miss_then_hit done, %0d mismatches", errors - e0);
    endtask

    task automatic store_then_load();
        int e0;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            store_word(32'h0000_8000 + ($urandom % 64) * 4, 4'($urandom), $urandom);
        end
        foreach (stored_addrs[i]) load_and_check("merged store", stored_addrs[i]);
        $display("store_then_load done, %0d mismatches", errors - e0);
    endtask

    task automatic dirty_eviction();
        logic [31:0] a_addr;
        int e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a_addr = 32'h0001_2000 + 32'(i) * 36;
            store_word(a_addr, 4'hf, $urandom);
            load_and_check("conflicting tag", a_addr + 32'h0002_0000);   // Same index
            load_and_check("written back word", a_addr);
        end
        // Dirty lines from earlier stores were evicted above
        foreach (stored_addrs[i]) load_and_check("evicted store", stored_addrs[i]);
        $display("dirty_eviction done, %0d mismatches", errors - e0);
    endtask

    task automatic simultaneous_misses();
        logic [31:0] i_addr;
        logic [31:0] d_addr;
        logic [31:0] i_word;
        logic [31:0] d_word;
        int i_lat;
        int d_lat;
        int e0;
        e0 = errors;
        for (int j = 0; j < 4; j++) begin
            i_addr = 32'h0003_0000 + 32'(j) * 36;
            d_addr = 32'h0005_0000 + 32'(j) * 32 + 32'(3 - j) * 4;
            fork
                imem_access(i_addr, i_word, i_lat);
                dmem_access(1'b0, d_addr, 4'h0, 32'h0, d_word, d_lat);
            join
            check("concurrent ifetch", i_word, expected_word(i_addr));
            check("concurrent load", d_word, expected_word(d_addr));
        end
        $display("simultaneous_misses done, %0d mismatches", errors - e0);
    endtask

    initial begin
        void'($urandom(32'hd6f46086));
        clk      = 1'b0;
        rst_n    = 1'b0;
        imem_req = '0;
        dmem_req = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        idle_after_reset();
        ifetch_miss_then_hit();
        store_then_load();
        dirty_eviction();
        simultaneous_misses();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
cache_pkg.sv
word_lane_unit.sv
cache_core.sv
mem_arbiter.sv
cache_hierarchy.sv
cache_hierarchy_sva.sv
pmem_model.sv
tb_cache_hierarchy.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
    --top-module tb_cache_hierarchy || exit 1
out=$(./obj_dir/Vtb_cache_hierarchy 2>&1)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
